// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := me_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0 -Wno-fatal
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/me_ref_model.svh ====
`ifndef ME_REF_MODEL_SVH
`define ME_REF_MODEL_SVH

// cost of one candidate, pairwise floor averages down to one value
function automatic cost_t ref_cost(input blk_pix_t tgt, input pixel_t win [WIN_PIX],
		input int dy, input int dx);
	int lvl [BLK_PIX];
	int t;
	int w;
	int n;
	for (int j = 0; j < BLK_PIX; j++) begin
		t = tgt[j];
		w = win[(dy + j / BLK_COLS) * WIN_COLS + dx + j % BLK_COLS];
		lvl[j] = (t > w) ? t - w : w - t;
	end
	// in place, each level half as long as the one before
	n = BLK_PIX;
	while (n > 1) begin
		n = n / 2;
		for (int k = 0; k < n; k++)
			lvl[k] = (lvl[2*k] + lvl[2*k+1]) / 2;
	end
	return cost_t'(lvl[0]);
endfunction

// dy-major sweep, strictly smaller replaces
function automatic void ref_best(input blk_pix_t tgt, input pixel_t win [WIN_PIX],
		output mv_t mv, output cost_t cost);
	cost_t c;
	mv   = '0;
	cost = ref_cost(tgt, win, 0, 0);
	for (int dy = 0; dy < MV_RANGE; dy++) begin
		for (int dx = 0; dx < MV_RANGE; dx++) begin
			c = ref_cost(tgt, win, dy, dx);
			if (c < cost) begin
				cost = c;
				mv   = mv_t'(dy * MV_RANGE + dx);
			end
		end
	end
endfunction

`endif

// ==== bench/me_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module me_tb;

	import me_pkg::*;

	`include "me_ref_model.svh"

	localparam int N_BLOCKS   = 10;
	localparam int MAX_CYCLES = N_BLOCKS * (LOAD_PIX * 6 + 200);

	logic     clk;
	logic     rst_n;
	logic     pix_req;
	pixel_t   pix_data;
	logic     pix_ack;
	logic     res_req;
	mv_t      res_mv;
	cost_t    res_cost;
	logic     res_ack;

	blk_pix_t tgt_buf;
	pixel_t   win_buf [WIN_PIX];

	// expected results per loaded block
	mv_t      exp_mv_q [$];
	cost_t    exp_cost_q [$];
	bit       exp_bp_q [$];    // hold ack back for this block

	int       cycles       = 0;
	int       loads_done   = 0;
	int       results_done = 0;
	int       mv_errors    = 0;
	int       cost_errors  = 0;
	int       proto_errors = 0;

	me_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix_req_i  (pix_req),
		.pix_data_i (pix_data),
		.pix_ack_o  (pix_ack),
		.res_req_o  (res_req),
		.res_mv_o   (res_mv),
		.res_cost_o (res_cost),
		.res_ack_i  (res_ack)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ================================================
	// compare tasks
	// ================================================
	task automatic check_mv(input mv_t got, input mv_t exp, input string msg);
		if (got !== exp) begin
			mv_errors++;
			$display("CHECK FAILED at %0t: %s, got dy=%0d dx=%0d, expected dy=%0d dx=%0d",
				$time, msg, got[5:3], got[2:0], exp[5:3], exp[2:0]);
		end
	endtask

	task automatic check_cost(input cost_t got, input cost_t exp, input string msg);
		if (got !== exp) begin
			cost_errors++;
			$display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
		end
	endtask

	// ================================================
	// stimulus
	// ================================================
	// four-phase handshake starting at a rising edge
	task automatic send_pixel(input pixel_t p);
		pix_data <= p;
		pix_req  <= 1'b1;
		do @(posedge clk); while (!pix_ack);
		pix_req <= 1'b0;
		do @(posedge clk); while (pix_ack);
	endtask

	task automatic load_block(input bit bp);
		mv_t   e_mv;
		cost_t e_cost;
		ref_best(tgt_buf, win_buf, e_mv, e_cost);
		exp_mv_q.push_back(e_mv);
		exp_cost_q.push_back(e_cost);
		exp_bp_q.push_back(bp);
		for (int j = 0; j < BLK_PIX; j++)
			send_pixel(tgt_buf[j]);
		for (int i = 0; i < WIN_PIX; i++)
			send_pixel(win_buf[i]);
		loads_done++;
	endtask

	task automatic fill_random();
		for (int j = 0; j < BLK_PIX; j++)
			tgt_buf[j] = pixel_t'($urandom);
		for (int i = 0; i < WIN_PIX; i++)
			win_buf[i] = pixel_t'($urandom);
	endtask

	// exact copy of the target at (dy, dx)
	task automatic plant_copy(input int dy, input int dx);
		for (int j = 0; j < BLK_PIX; j++)
			win_buf[(dy + j / BLK_COLS) * WIN_COLS + dx + j % BLK_COLS] = tgt_buf[j];
	endtask

	task automatic fill_levels(input pixel_t t, input pixel_t w);
		for (int j = 0; j < BLK_PIX; j++)
			tgt_buf[j] = t;
		for (int i = 0; i < WIN_PIX; i++)
			win_buf[i] = w;
	endtask

	task automatic fill_alternating();
		for (int j = 0; j < BLK_PIX; j++)
			tgt_buf[j] = (j % 2) ? 8'hff : 8'h00;
		for (int i = 0; i < WIN_PIX; i++)
			win_buf[i] = ((i / WIN_COLS + i) % 3 == 0) ? 8'hff : 8'h00;
	endtask

	// ================================================
	// result side of the output handshake
	// ================================================
	initial begin : result_side
		mv_t   held_mv;
		cost_t held_cost;
		bit    bp;
		int    hold;
		forever begin
			do @(posedge clk); while (res_req !== 1'b1);
			bp = 1'b0;
			if (exp_mv_q.size() == 0) begin
				proto_errors++;
				$display("result offered at %0t with no block loaded", $time);
			end else begin
				check_mv(res_mv, exp_mv_q.pop_front(), "result vector");
				check_cost(res_cost, exp_cost_q.pop_front(), "result cost");
				bp = exp_bp_q.pop_front();
			end
			held_mv   = res_mv;
			held_cost = res_cost;
			if (bp) begin
				hold = 20 + $urandom % 41;
				repeat (hold) begin
					@(posedge clk);
					if (res_req !== 1'b1) begin
						proto_errors++;
						$display("res_req_o dropped at %0t before ack was given", $time);
					end
					check_mv(res_mv, held_mv, "vector moved under back-pressure");
					check_cost(res_cost, held_cost, "cost moved under back-pressure");
				end
			end
			res_ack <= 1'b1;
			do @(posedge clk); while (res_req);
			res_ack <= 1'b0;
			results_done++;
		end
	end

	// cycle limit and ack watch
	always @(posedge clk) begin
		cycles++;
		if (pix_ack === 1'b1 && loads_done > results_done) begin
			proto_errors++;
			$display("pixel acknowledged at %0t while a search was still running", $time);
		end
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// ================================================
	// main sequence
	// ================================================
	initial begin : main_seq
		int     total;
		int     pdy;
		int     pdx;
		pixel_t flat;
		rst_n    = 1'b0;
		pix_req  = 1'b0;
		pix_data = '0;
		res_ack  = 1'b0;
		void'($urandom(1658));

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		if (pix_ack !== 1'b0 || res_req !== 1'b0) begin
			proto_errors++;
			$display("handshake outputs not low after reset");
		end

		for (int b = 0; b < 4; b++) begin
			fill_random();
			load_block(1'b0);
		end
		for (int b = 0; b < 2; b++) begin
			fill_random();
			pdy = $urandom % MV_RANGE;
			pdx = $urandom % MV_RANGE;
			plant_copy(pdy, pdx);
			load_block(1'b0);
		end
		flat = pixel_t'($urandom);
		fill_levels(flat, flat);    // every pixel equal so every cost is zero
		load_block(1'b0);
		fill_random();
		load_block(1'b1);    // slow ack while the next block's pixels wait
		fill_levels(8'hff, 8'h00);
		load_block(1'b0);
		fill_alternating();
		load_block(1'b0);

		wait (results_done == loads_done);
		@(posedge clk);
		total = mv_errors + cost_errors + proto_errors;
		$display("errors: vector %0d, cost %0d, protocol %0d, blocks %0d",
			mv_errors, cost_errors, proto_errors, results_done);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+bench
hdl/me_pkg.sv
hdl/window_buffer.sv
hdl/search_ctrl.sv
hdl/abs_diff_array.sv
hdl/avg_reduce_tree.sv
hdl/best_select.sv
hdl/me_top.sv
bench/me_tb.sv

// ==== hdl/abs_diff_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module abs_diff_array (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire me_pkg::blk_pix_t tgt_pix_i,
	input  wire me_pkg::blk_pix_t win_pix_i,
	input  wire                   valid_i,
	input  wire me_pkg::mv_t      mv_i,
	input  wire                   last_i,
	output me_pkg::blk_pix_t      diff_o,
	output logic                  valid_o,
	output me_pkg::mv_t           mv_o,
	output logic                  last_o
);

	import me_pkg::*;

	// tag control bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_o <= 1'b0;
			last_o  <= 1'b0;
		end else begin
			valid_o <= valid_i;
			last_o  <= last_i;
		end
	end

	// |target - window| per pixel, larger minus smaller
	always_ff @(posedge clk) begin
		mv_o <= mv_i;
		for (int j = 0; j < BLK_PIX; j++) begin
			if (tgt_pix_i[j] > win_pix_i[j])
				diff_o[j] <= tgt_pix_i[j] - win_pix_i[j];
			else
				diff_o[j] <= win_pix_i[j] - tgt_pix_i[j];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/avg_reduce_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module avg_reduce_tree #(
	parameter int N_IN = 32
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire me_pkg::blk_pix_t diff_i,
	input  wire                   valid_i,
	input  wire me_pkg::mv_t      mv_i,
	input  wire                   last_i,
	output me_pkg::cost_t         cost_o,
	output logic                  valid_o,
	output me_pkg::mv_t           mv_o,
	output logic                  last_o
);

	import me_pkg::*;

	localparam int LEVELS = $clog2(N_IN);

	// heap numbering: node k feeds from 2k and 2k+1, root is node 1
	pixel_t            node_q [1:N_IN-1];
	logic [LEVELS-1:0] valid_q;
	logic [LEVELS-1:0] last_q;
	mv_t               mv_q [LEVELS];

	// floor((a + b) / 2) without overflow
	function automatic pixel_t avg2(input pixel_t a, input pixel_t b);
		logic [PIX_W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[PIX_W:1];
	endfunction

	// ================================================
	// one register stage per level
	// ================================================
	for (genvar l = 0; l < LEVELS; l++) begin : gen_lvl
		localparam int FIRST = N_IN >> (l + 1);
		for (genvar k = FIRST; k < 2 * FIRST; k++) begin : gen_node
			if (l == 0) begin : gen_leaf
				always_ff @(posedge clk) begin
					node_q[k] <= avg2(diff_i[2*k - N_IN], diff_i[2*k + 1 - N_IN]);
				end
			end else begin : gen_inner
				always_ff @(posedge clk) begin
					node_q[k] <= avg2(node_q[2*k], node_q[2*k + 1]);
				end
			end
		end
	end

	// tag walks alongside the levels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			last_q  <= '0;
		end else begin
			valid_q <= {valid_q[LEVELS-2:0], valid_i};
			last_q  <= {last_q[LEVELS-2:0], last_i};
		end
	end

	always_ff @(posedge clk) begin
		mv_q[0] <= mv_i;
		for (int l = 1; l < LEVELS; l++)
			mv_q[l] <= mv_q[l-1];
	end

	assign cost_o  = node_q[1];
	assign valid_o = valid_q[LEVELS-1];
	assign last_o  = last_q[LEVELS-1];
	assign mv_o    = mv_q[LEVELS-1];

endmodule

`default_nettype wire

// ==== hdl/best_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module best_select (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   valid_i,
	input  wire me_pkg::cost_t    cost_i,
	input  wire me_pkg::mv_t      mv_i,
	input  wire                   last_i,
	output logic                  best_valid_o,
	output me_pkg::mv_t           best_mv_o,
	output me_pkg::cost_t         best_cost_o
);

	import me_pkg::*;

	logic have_q;    // at least one item of this search seen
	logic take;

	// strictly smaller only, so the earliest candidate keeps a tie
	assign take = valid_i && (!have_q || cost_i < best_cost_o);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			have_q       <= 1'b0;
			best_valid_o <= 1'b0;
		end else begin
			best_valid_o <= valid_i && last_i;
			if (valid_i)
				have_q <= !last_i;    // rearm after the last candidate
		end
	end

	// running best, final value shows with the pulse
	always_ff @(posedge clk) begin
		if (take) begin
			best_mv_o   <= mv_i;
			best_cost_o <= cost_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/me_pkg.sv ====
`default_nettype none

package me_pkg;

	// ================================================
	// block and search window geometry
	// ================================================
	localparam int PIX_W    = 8;
	localparam int BLK_ROWS = 4;
	localparam int BLK_COLS = 8;
	localparam int BLK_PIX  = BLK_ROWS * BLK_COLS;    // 32

	localparam int MV_RANGE = 8;    // offsets 0..7 on each axis
	localparam int WIN_ROWS = BLK_ROWS + MV_RANGE - 1;    // 11
	localparam int WIN_COLS = BLK_COLS + MV_RANGE - 1;    // 15
	localparam int WIN_PIX  = WIN_ROWS * WIN_COLS;        // 165

	// target first, window after it
	localparam int LOAD_PIX = BLK_PIX + WIN_PIX;          // 197

	localparam int TREE_LEVELS = $clog2(BLK_PIX);         // 5

	// ================================================
	// data types
	// ================================================
	typedef logic [PIX_W-1:0] pixel_t;

	// truncated averages never leave the pixel range
	typedef logic [PIX_W-1:0] cost_t;

	// dy in [5:3], dx in [2:0]
	typedef logic [2*$clog2(MV_RANGE)-1:0] mv_t;

	// one block worth of pixels, element j is row j/8, col j%8
	typedef pixel_t [BLK_PIX-1:0] blk_pix_t;

endpackage

`default_nettype wire

// ==== hdl/me_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module me_top #(
	parameter int LOAD_PIX = me_pkg::LOAD_PIX,
	parameter int N_IN     = me_pkg::BLK_PIX
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   pix_req_i,
	input  wire me_pkg::pixel_t   pix_data_i,
	output logic                  pix_ack_o,
	output logic                  res_req_o,
	output me_pkg::mv_t           res_mv_o,
	output me_pkg::cost_t         res_cost_o,
	input  wire                   res_ack_i
);

	import me_pkg::*;

	// control
	logic     load_en;
	logic     load_done;
	logic     cand_valid;
	mv_t      cand_mv;
	logic     cand_last;

	// candidate pixels
	blk_pix_t tgt_pix;
	blk_pix_t win_pix;

	// abs diff stage
	blk_pix_t ad_diff;
	logic     ad_valid;
	mv_t      ad_mv;
	logic     ad_last;

	// tree output
	cost_t    tr_cost;
	logic     tr_valid;
	mv_t      tr_mv;
	logic     tr_last;

	// winner
	logic     best_valid;
	mv_t      best_mv;
	cost_t    best_cost;

	// ================================================
	// storage and control
	// ================================================
	window_buffer #(
		.LOAD_PIX(LOAD_PIX)
	) u_window_buffer (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_en_i   (load_en),
		.pix_req_i   (pix_req_i),
		.pix_data_i  (pix_data_i),
		.cand_mv_i   (cand_mv),
		.pix_ack_o   (pix_ack_o),
		.load_done_o (load_done),
		.tgt_pix_o   (tgt_pix),
		.win_pix_o   (win_pix)
	);

	search_ctrl u_search_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.load_done_i  (load_done),
		.best_valid_i (best_valid),
		.best_mv_i    (best_mv),
		.best_cost_i  (best_cost),
		.res_ack_i    (res_ack_i),
		.load_en_o    (load_en),
		.cand_valid_o (cand_valid),
		.cand_mv_o    (cand_mv),
		.cand_last_o  (cand_last),
		.res_req_o    (res_req_o),
		.res_mv_o     (res_mv_o),
		.res_cost_o   (res_cost_o)
	);

	// ================================================
	// cost pipeline, 1 + 5 + 1 cycles
	// ================================================
	abs_diff_array u_abs_diff_array (
		.clk       (clk),
		.rst_n     (rst_n),
		.tgt_pix_i (tgt_pix),
		.win_pix_i (win_pix),
		.valid_i   (cand_valid),
		.mv_i      (cand_mv),
		.last_i    (cand_last),
		.diff_o    (ad_diff),
		.valid_o   (ad_valid),
		.mv_o      (ad_mv),
		.last_o    (ad_last)
	);

	avg_reduce_tree #(
		.N_IN(N_IN)
	) u_avg_reduce_tree (
		.clk     (clk),
		.rst_n   (rst_n),
		.diff_i  (ad_diff),
		.valid_i (ad_valid),
		.mv_i    (ad_mv),
		.last_i  (ad_last),
		.cost_o  (tr_cost),
		.valid_o (tr_valid),
		.mv_o    (tr_mv),
		.last_o  (tr_last)
	);

	best_select u_best_select (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid_i      (tr_valid),
		.cost_i       (tr_cost),
		.mv_i         (tr_mv),
		.last_i       (tr_last),
		.best_valid_o (best_valid),
		.best_mv_o    (best_mv),
		.best_cost_o  (best_cost)
	);

endmodule

`default_nettype wire

// ==== hdl/search_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module search_ctrl (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   load_done_i,
	input  wire                   best_valid_i,
	input  wire me_pkg::mv_t      best_mv_i,
	input  wire me_pkg::cost_t    best_cost_i,
	input  wire                   res_ack_i,
	output logic                  load_en_o,
	output logic                  cand_valid_o,
	output me_pkg::mv_t           cand_mv_o,
	output logic                  cand_last_o,
	output logic                  res_req_o,
	output me_pkg::mv_t           res_mv_o,
	output me_pkg::cost_t         res_cost_o
);

	import me_pkg::*;

	localparam int N_CAND = MV_RANGE * MV_RANGE;
	localparam int CNT_W  = $clog2(N_CAND) + 1;    // top bit set once all issued

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_SCAN,
		ST_REPORT
	} state_t;

	state_t           state_q;
	logic [CNT_W-1:0] cand_q;

	assign load_en_o    = (state_q == ST_LOAD);
	assign cand_valid_o = (state_q == ST_SCAN) && !cand_q[CNT_W-1];
	assign cand_mv_o    = cand_q[CNT_W-2:0];    // dx in low bits, so dy-major
	assign cand_last_o  = cand_valid_o && (cand_q[CNT_W-2:0] == '1);

	// ================================================
	// load / scan / report
	// ================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= ST_LOAD;
			cand_q    <= '0;
			res_req_o <= 1'b0;
		end else begin
			case (state_q)
				ST_LOAD: begin
					cand_q <= '0;
					if (load_done_i)
						state_q <= ST_SCAN;
				end
				ST_SCAN: begin
					if (!cand_q[CNT_W-1])
						cand_q <= cand_q + 1'b1;
					// pipeline drains, then best_select reports
					if (best_valid_i) begin
						state_q   <= ST_REPORT;
						res_req_o <= 1'b1;
					end
				end
				ST_REPORT: begin
					if (res_req_o && res_ack_i)
						res_req_o <= 1'b0;
					else if (!res_req_o && !res_ack_i)
						state_q <= ST_LOAD;    // four phases done
				end
				default: state_q <= ST_LOAD;
			endcase
		end
	end

	// result held stable for the whole handshake
	always_ff @(posedge clk) begin
		if (state_q == ST_SCAN && best_valid_i) begin
			res_mv_o   <= best_mv_i;
			res_cost_o <= best_cost_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/window_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_buffer #(
	parameter int LOAD_PIX = me_pkg::LOAD_PIX
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   load_en_i,
	input  wire                   pix_req_i,
	input  wire me_pkg::pixel_t   pix_data_i,
	input  wire me_pkg::mv_t      cand_mv_i,
	output logic                  pix_ack_o,
	output logic                  load_done_o,
	output me_pkg::blk_pix_t      tgt_pix_o,
	output me_pkg::blk_pix_t      win_pix_o
);

	import me_pkg::*;

	localparam int CNT_W  = $clog2(LOAD_PIX + 1);
	localparam int TGT_AW = $clog2(BLK_PIX);

	logic [CNT_W-1:0] cnt_q;     // pixels stored so far
	logic [CNT_W-1:0] win_addr;
	logic             ack_q;
	logic             take;      // pixel captured this cycle
	blk_pix_t         tgt_q;
	pixel_t           win_q [WIN_PIX];

	assign take      = load_en_i && pix_req_i && !ack_q && (cnt_q < CNT_W'(LOAD_PIX));
	assign win_addr  = cnt_q - CNT_W'(BLK_PIX);
	assign pix_ack_o = ack_q;
	assign tgt_pix_o = tgt_q;

	// ================================================
	// ack side of the pixel handshake
	// ================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q       <= 1'b0;
			cnt_q       <= '0;
			load_done_o <= 1'b0;
		end else begin
			load_done_o <= take && (cnt_q == CNT_W'(LOAD_PIX - 1));

			if (take)
				ack_q <= 1'b1;
			else if (!pix_req_i)
				ack_q <= 1'b0;    // source has let go

			if (!load_en_i)
				cnt_q <= '0;    // next load starts over
			else if (take)
				cnt_q <= cnt_q + 1'b1;
		end
	end

	// pixel storage, count decides target or window
	always_ff @(posedge clk) begin
		if (take) begin
			if (cnt_q < CNT_W'(BLK_PIX))
				tgt_q[cnt_q[TGT_AW-1:0]] <= pix_data_i;
			else
				win_q[win_addr] <= pix_data_i;
		end
	end

	// ================================================
	// candidate selection
	// ================================================
	always_comb begin
		int unsigned row;
		int unsigned col;
		for (int j = 0; j < BLK_PIX; j++) begin
			row = cand_mv_i[5:3] + j / BLK_COLS;    // dy + block row
			col = cand_mv_i[2:0] + j % BLK_COLS;    // dx + block col
			win_pix_o[j] = win_q[row * WIN_COLS + col];
		end
	end

endmodule

`default_nettype wire
